//--- tb.f
+incdir+source
source/riscboy_pkg.sv
source/fpga_reset.sv
source/uart_link.sv
source/cmd_decode.sv
source/gpio_execute.sv
source/resp_result.sv
source/riscboy_core.sv
source/riscboy_fpga.sv
sim/tb_clkgen.sv
sim/riscboy_asserts.sv
sim/tb_riscboy_fpga.sv

//--- sim/tb_riscboy_fpga.sv
`timescale 1ns/1ps

module tb_riscboy_fpga import riscboy_pkg::*; ();

`include "gpio_pinmap.svh"

	localparam int        CLK_DIV        = 8;
	localparam int        SHIFT          = 3;
	localparam int        COUNT          = 20;
	localparam gpio_vec_t PAD_INVERT     = 8'h04;
	localparam int        RESET_CYCLES   = 5;
	localparam int        N_RANDOM       = 200;
	localparam int        N_COMMANDS     = 220;
	localparam int        TIMEOUT_CYCLES = RESET_CYCLES + SHIFT + COUNT
		+ 40 * CLK_DIV * N_COMMANDS;

	logic       clk;
	logic       rst_n;
	logic [6:0] led;
	logic       uart_tx;
	logic       uart_rx;
	logic [3:0] dpad_lv;
	logic [31:0] lfsr_q;
	gpio_vec_t  m_padout;
	gpio_vec_t  m_padoe;
	int         error_count;
	int         check_count;
	int         cycle_count;
	int         errs;

	tb_clkgen #(.PERIOD_NS(10.0)) clkgen0 (.clk(clk));

	riscboy_fpga #(
		.CLK_DIV    (CLK_DIV),
		.PAD_INVERT (PAD_INVERT),
		.SHIFT      (SHIFT),
		.COUNT      (COUNT)
	) dut0 (
		.clk_osc (clk),
		.rst_n   (rst_n),
		.led     (led),
		.uart_tx (uart_tx),
		.uart_rx (uart_rx),
		.dpad_u  (dpad_lv[PIN_DPAD_U]),
		.dpad_d  (dpad_lv[PIN_DPAD_D]),
		.dpad_l  (dpad_lv[PIN_DPAD_L]),
		.dpad_r  (dpad_lv[PIN_DPAD_R])
	);

	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("timeout: run still going after %0d clock cycles", cycle_count);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// taps 32, 22, 2, 1.
	function automatic logic lfsr_bit();
		logic fb;
		fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
		lfsr_q = {lfsr_q[30:0], fb};
		return fb;
	endfunction

	function automatic logic [31:0] random_bits(int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[30:0], lfsr_bit()};
		return v;
	endfunction

	function automatic uart_byte_t make_cmd(gpio_op_t o);
		return {2'(o), 6'(random_bits(6))};
	endfunction

	// led rule from the pins and the gpio model.
	function automatic logic [6:0] led_from_model(logic tx_line);
		return {~tx_line, ~uart_rx, dpad_lv[PIN_DPAD_U], dpad_lv[PIN_DPAD_D],
			dpad_lv[PIN_DPAD_L], ~dpad_lv[PIN_DPAD_R],
			~(m_padout[PIN_LED] & m_padoe[PIN_LED])};
	endfunction

	task automatic step();
		@(posedge clk);
		#1;
	endtask

	task automatic check_byte(string name, uart_byte_t got, uart_byte_t exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic check_led(logic [6:0] got, logic [6:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED led: got %h, expected %h", got, exp);
		end
	endtask

	task automatic check_line(string name, logic got, logic exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic report_test(string name, int errors_at_start);
		if (error_count == errors_at_start)
			$display("%s: ok", name);
		else
			$display("%s: %0d errors", name, error_count - errors_at_start);
	endtask

	// 8N1 frame, lsb first.
	task automatic send_byte(uart_byte_t b);
		uart_rx = 1'b0;
		repeat (CLK_DIV / 2) step();
		// rx activity shows on the led while the start bit is low.
		check_led(led, led_from_model(1'b1));
		repeat (CLK_DIV - CLK_DIV / 2) step();
		for (int i = 0; i < 8; i++) begin
			uart_rx = b[i];
			repeat (CLK_DIV) step();
		end
		uart_rx = 1'b1;
		repeat (CLK_DIV) step();
	endtask

	// returns at the middle of the stop bit.
	task automatic receive_byte(output uart_byte_t b);
		b = '0;
		do step(); while (uart_tx !== 1'b0);
		repeat (CLK_DIV / 2) step();
		// tx activity shows on the led during the start bit.
		check_led(led, led_from_model(1'b0));
		for (int i = 0; i < 8; i++) begin
			repeat (CLK_DIV) step();
			b[i] = uart_tx;
		end
		repeat (CLK_DIV) step();
		if (uart_tx !== 1'b1) begin
			error_count++;
			$display("response frame had a low stop bit");
		end
	endtask

	task automatic run_command(uart_byte_t cmd, uart_byte_t data);
		gpio_op_t   cmd_op;
		uart_byte_t expected;
		uart_byte_t resp;
		cmd_op = gpio_op_t'(cmd[7:6]);
		case (cmd_op)
		op_read_in:  expected = {m_padout[7:4] & m_padoe[7:4], dpad_lv ^ PAD_INVERT[3:0]};
		op_read_out: expected = m_padout;
		default:     expected = data;
		endcase
		// the response can start inside the last stop bit.
		fork
			begin
				send_byte(cmd);
				if (cmd_op == op_write_out || cmd_op == op_write_oe)
					send_byte(data);
				// registers change once the last byte is in.
				if (cmd_op == op_write_out)
					m_padout = data;
				else if (cmd_op == op_write_oe)
					m_padoe = data;
			end
			receive_byte(resp);
		join
		check_byte("uart response", resp, expected);
		check_led(led, led_from_model(1'b1));
	endtask

	initial begin
		gpio_op_t  o;
		gpio_vec_t data;
		rst_n       = 1'b0;
		uart_rx     = 1'b1;
		dpad_lv     = 4'h0;
		lfsr_q      = 32'h49fb4bfa;
		m_padout    = '0;
		m_padoe     = '0;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;

		errs = error_count;
		repeat (RESET_CYCLES) begin
			step();
			check_line("uart_tx", uart_tx, 1'b1);
		end
		rst_n = 1'b1;
		repeat (SHIFT + COUNT + 8) begin
			step();
			check_line("uart_tx", uart_tx, 1'b1);
		end
		check_led(led, led_from_model(1'b1));
		report_test("reset and idle", errs);

		errs = error_count;
		repeat (2) begin
			run_command(make_cmd(op_write_out), 8'(random_bits(8)));
			run_command(make_cmd(op_write_oe), 8'(random_bits(8)));
			run_command(make_cmd(op_read_out), 8'h00);
		end
		report_test("write and readback", errs);

		errs = error_count;
		repeat (6) begin
			dpad_lv = 4'(random_bits(4));
			repeat (4) step();
			run_command(make_cmd(op_read_in), 8'h00);
		end
		report_test("d-pad inputs", errs);

		// every padout/padoe combination on the led pad.
		errs = error_count;
		for (int k = 0; k < 4; k++) begin
			data = 8'(random_bits(8));
			data[PIN_LED] = k[0];
			run_command(make_cmd(op_write_out), data);
			data = 8'(random_bits(8));
			data[PIN_LED] = k[1];
			run_command(make_cmd(op_write_oe), data);
		end
		report_test("led mapping", errs);

		errs = error_count;
		repeat (N_RANDOM) begin
			dpad_lv = 4'(random_bits(4));
			o = gpio_op_t'(random_bits(2));
			if (o == op_write_out || o == op_write_oe)
				data = 8'(random_bits(8));
			else
				data = 8'h00;
			run_command(make_cmd(o), data);
		end
		report_test("random commands", errs);

		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

//--- sim/riscboy_asserts.sv
`timescale 1ns/1ps

module riscboy_asserts (
	input logic clk_sys,
	input logic rst_n,
	input logic rx_valid,
	input logic op_valid,
	input logic result_valid,
	input logic tx_start,
	input logic tx_busy,
	input logic uart_tx
);

	// execute answers every decoded operation one clock later.
	a_exec_follows: assert property (@(posedge clk_sys) disable iff (!rst_n)
		op_valid |=> result_valid)
		else $error("result_valid did not follow op_valid");

	a_start_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_start |-> !tx_busy)
		else $error("tx_start while the transmitter was busy");

	// strobes are single-cycle pulses.
	a_rx_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		rx_valid |=> !rx_valid)
		else $error("rx_valid held longer than one clock");
	a_op_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		op_valid |=> !op_valid)
		else $error("op_valid held longer than one clock");
	a_result_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		result_valid |=> !result_valid)
		else $error("result_valid held longer than one clock");
	a_tx_pulse: assert property (@(posedge clk_sys) disable iff (!rst_n)
		tx_start |=> !tx_start)
		else $error("tx_start held longer than one clock");

	// line rests high between frames.
	a_line_idle: assert property (@(posedge clk_sys) disable iff (!rst_n)
		!tx_busy |-> uart_tx)
		else $error("uart_tx low while the transmitter was idle");

endmodule

bind riscboy_core riscboy_asserts asserts0 (
	.clk_sys      (clk_sys),
	.rst_n        (rst_n),
	.rx_valid     (rx_valid),
	.op_valid     (op_valid),
	.result_valid (result_valid),
	.tx_start     (tx_start),
	.tx_busy      (tx_busy),
	.uart_tx      (uart_tx)
);

//--- sim/tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
	parameter real PERIOD_NS = 10.0
) (
	output logic clk
);

	// free running, starts low.
	initial clk = 1'b0;

	always #(PERIOD_NS / 2.0) clk = ~clk;

endmodule

//--- source/riscboy_fpga.sv
`timescale 1ns/1ps

module riscboy_fpga import riscboy_pkg::*; #(
	parameter int        CLK_DIV    = 104,
	parameter gpio_vec_t PAD_INVERT = 8'h04,
	parameter int        SHIFT      = 3,
	parameter int        COUNT      = 200
) (
	input  logic       clk_osc,
	input  logic       rst_n,

	output logic [6:0] led,

	output logic       uart_tx,
	input  logic       uart_rx,

	input  logic       dpad_u,
	input  logic       dpad_d,
	input  logic       dpad_l,
	input  logic       dpad_r
);

`include "gpio_pinmap.svh"

	logic      sys_rst_n;
	gpio_vec_t padout;
	gpio_vec_t padoe;
	gpio_vec_t padin;

	// clk_osc runs the whole design, no pll here.
	fpga_reset #(
		.SHIFT (SHIFT),
		.COUNT (COUNT)
	) rstgen (
		.clk         (clk_osc),
		.force_rst_n (rst_n),
		.rst_n       (sys_rst_n)
	);

	riscboy_core #(
		.CLK_DIV    (CLK_DIV),
		.PAD_INVERT (PAD_INVERT)
	) core (
		.clk_sys (clk_osc),
		.rst_n   (sys_rst_n),
		.uart_rx (uart_rx),
		.uart_tx (uart_tx),
		.padout  (padout),
		.padoe   (padoe),
		.padin   (padin)
	);

	// pads without a pin read back their own driven level.
	always_comb begin
		padin             = padout & padoe;
		padin[PIN_DPAD_U] = dpad_u;
		padin[PIN_DPAD_D] = dpad_d;
		padin[PIN_DPAD_L] = dpad_l;
		padin[PIN_DPAD_R] = dpad_r;
	end

	// right button and user leds are active low on the main board.
	assign led = {
		!uart_tx,
		!uart_rx,
		padin[PIN_DPAD_U],
		padin[PIN_DPAD_D],
		padin[PIN_DPAD_L],
		!padin[PIN_DPAD_R],
		!(padout[PIN_LED] && padoe[PIN_LED])
	};

endmodule

//--- source/riscboy_core.sv
`timescale 1ns/1ps

module riscboy_core import riscboy_pkg::*; #(
	parameter int        CLK_DIV    = 104,
	parameter gpio_vec_t PAD_INVERT = 8'h04
) (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  logic      uart_rx,
	output logic      uart_tx,
	output gpio_vec_t padout,
	output gpio_vec_t padoe,
	input  gpio_vec_t padin
);

`include "gpio_pinmap.svh"

	// pad vectors must cover every pad in the pin map.
	if ($bits(gpio_vec_t) != N_GPIOS) begin : g_pad_width_check
		$error("gpio_vec_t width does not match N_GPIOS");
	end

	uart_byte_t rx_data;
	logic       rx_valid;
	uart_byte_t tx_data;
	logic       tx_start;
	logic       tx_busy;
	gpio_op_t   op;
	gpio_vec_t  operand;
	logic       op_valid;
	gpio_vec_t  result;
	logic       result_valid;

	uart_link #(
		.CLK_DIV (CLK_DIV)
	) uart0 (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.uart_rx  (uart_rx),
		.uart_tx  (uart_tx),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.tx_data  (tx_data),
		.tx_start (tx_start),
		.tx_busy  (tx_busy)
	);

	cmd_decode decode (
		.clk_sys  (clk_sys),
		.rst_n    (rst_n),
		.rx_data  (rx_data),
		.rx_valid (rx_valid),
		.op       (op),
		.operand  (operand),
		.op_valid (op_valid)
	);

	gpio_execute #(
		.PAD_INVERT (PAD_INVERT)
	) execute (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.op           (op),
		.operand      (operand),
		.op_valid     (op_valid),
		.padin        (padin),
		.padout       (padout),
		.padoe        (padoe),
		.result       (result),
		.result_valid (result_valid)
	);

	resp_result respond (
		.clk_sys      (clk_sys),
		.rst_n        (rst_n),
		.result       (result),
		.result_valid (result_valid),
		.tx_busy      (tx_busy),
		.tx_data      (tx_data),
		.tx_start     (tx_start)
	);

endmodule

//--- source/resp_result.sv
`timescale 1ns/1ps

module resp_result import riscboy_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  gpio_vec_t  result,
	input  logic       result_valid,
	input  logic       tx_busy,
	output uart_byte_t tx_data,
	output logic       tx_start
);

	logic pending;

	// tx_data doubles as the one-entry slot.
	always_ff @(posedge clk_sys) begin
		if (result_valid)
			tx_data <= result;
	end

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			pending  <= 1'b0;
			tx_start <= 1'b0;
		end else begin
			tx_start <= 1'b0;
			if (result_valid) begin
				// straight through when the line is free.
				if (tx_busy)
					pending <= 1'b1;
				else
					tx_start <= 1'b1;
			end else if (pending && !tx_busy) begin
				pending  <= 1'b0;
				tx_start <= 1'b1;
			end
		end
	end

endmodule

//--- source/gpio_execute.sv
`timescale 1ns/1ps

module gpio_execute import riscboy_pkg::*; #(
	parameter gpio_vec_t PAD_INVERT = 8'h04
) (
	input  logic      clk_sys,
	input  logic      rst_n,
	input  gpio_op_t  op,
	input  gpio_vec_t operand,
	input  logic      op_valid,
	input  gpio_vec_t padin,
	output gpio_vec_t padout,
	output gpio_vec_t padoe,
	output gpio_vec_t result,
	output logic      result_valid
);

	gpio_vec_t padin_meta;
	gpio_vec_t padin_sync;
	gpio_vec_t padin_cond;

	// per-pad polarity fix after the synchronizer.
	assign padin_cond = padin_sync ^ PAD_INVERT;

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			padin_meta   <= '0;
			padin_sync   <= '0;
			padout       <= '0;
			padoe        <= '0;
			result_valid <= 1'b0;
		end else begin
			padin_meta   <= padin;
			padin_sync   <= padin_meta;
			result_valid <= op_valid;
			if (op_valid) begin
				case (op)
				op_write_out: padout <= operand;
				op_write_oe:  padoe  <= operand;
				default: ;
				endcase
			end
		end
	end

	// response byte, valid alongside result_valid.
	always_ff @(posedge clk_sys) begin
		if (op_valid) begin
			case (op)
			op_read_in:   result <= padin_cond;
			op_write_out: result <= operand;
			op_write_oe:  result <= operand;
			op_read_out:  result <= padout;
			default:      result <= padout;
			endcase
		end
	end

endmodule

//--- source/cmd_decode.sv
`timescale 1ns/1ps

module cmd_decode import riscboy_pkg::*; (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  uart_byte_t rx_data,
	input  logic       rx_valid,
	output gpio_op_t   op,
	output gpio_vec_t  operand,
	output logic       op_valid
);

	decode_state_t state;
	gpio_op_t      cmd_op;
	logic          cmd_has_data;

	assign cmd_op = gpio_op_t'(rx_data[7:6]);

	// writes carry a second byte.
	assign cmd_has_data = (cmd_op == op_write_out) || (cmd_op == op_write_oe);

	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			state    <= dec_wait_cmd;
			op       <= op_read_in;
			op_valid <= 1'b0;
		end else begin
			op_valid <= 1'b0;
			case (state)
			dec_wait_cmd: if (rx_valid) begin
				op <= cmd_op;
				if (cmd_has_data)
					state <= dec_wait_data;
				else
					op_valid <= 1'b1;
			end
			dec_wait_data: if (rx_valid) begin
				// opcode was latched with the first byte.
				op_valid <= 1'b1;
				state    <= dec_wait_cmd;
			end
			default: state <= dec_wait_cmd;
			endcase
		end
	end

	// data byte of a write command.
	always_ff @(posedge clk_sys) begin
		if (state == dec_wait_data && rx_valid)
			operand <= rx_data;
	end

endmodule

//--- source/uart_link.sv
`timescale 1ns/1ps

module uart_link import riscboy_pkg::*; #(
	parameter int CLK_DIV = 104
) (
	input  logic       clk_sys,
	input  logic       rst_n,
	input  logic       uart_rx,
	output logic       uart_tx,
	output uart_byte_t rx_data,
	output logic       rx_valid,
	input  uart_byte_t tx_data,
	input  logic       tx_start,
	output logic       tx_busy
);

	localparam int W_DIV = $clog2(CLK_DIV);

	uart_state_t      rx_state;
	logic [1:0]       rx_sync;
	logic             rx_s;
	logic [W_DIV-1:0] rx_cnt;
	logic [2:0]       rx_bit;
	uart_byte_t       rx_shift;

	uart_state_t      tx_state;
	logic [W_DIV-1:0] tx_cnt;
	logic [2:0]       tx_bit;
	uart_byte_t       tx_shift;

	assign rx_s = rx_sync[1];

	// receiver; first count runs half a bit to land mid start bit.
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			rx_sync  <= 2'b11;
			rx_state <= uart_idle;
			rx_cnt   <= '0;
			rx_bit   <= '0;
			rx_valid <= 1'b0;
		end else begin
			rx_sync  <= {rx_sync[0], uart_rx};
			rx_valid <= 1'b0;
			if (rx_state != uart_idle && rx_cnt != '0) begin
				rx_cnt <= rx_cnt - 1'b1;
			end else begin
				case (rx_state)
				uart_idle: if (!rx_s) begin
					rx_state <= uart_start;
					rx_cnt   <= W_DIV'(CLK_DIV / 2 - 1);
				end
				uart_start: begin
					// a start bit that has gone high again was a glitch.
					rx_state <= rx_s ? uart_idle : uart_data;
					rx_cnt   <= W_DIV'(CLK_DIV - 1);
					rx_bit   <= '0;
				end
				uart_data: begin
					rx_cnt <= W_DIV'(CLK_DIV - 1);
					rx_bit <= rx_bit + 1'b1;
					if (rx_bit == 3'd7)
						rx_state <= uart_stop;
				end
				uart_stop: begin
					// framing error drops the byte.
					rx_valid <= rx_s;
					rx_state <= uart_idle;
				end
				default: rx_state <= uart_idle;
				endcase
			end
		end
	end

	// lsb first.
	always_ff @(posedge clk_sys) begin
		if (rx_state == uart_data && rx_cnt == '0)
			rx_shift <= {rx_s, rx_shift[7:1]};
	end

	assign rx_data = rx_shift;

	// transmitter.
	always_ff @(posedge clk_sys or negedge rst_n) begin
		if (!rst_n) begin
			tx_state <= uart_idle;
			tx_cnt   <= '0;
			tx_bit   <= '0;
			uart_tx  <= 1'b1;
		end else if (tx_state != uart_idle && tx_cnt != '0) begin
			tx_cnt <= tx_cnt - 1'b1;
		end else begin
			tx_cnt <= W_DIV'(CLK_DIV - 1);
			case (tx_state)
			uart_idle: if (tx_start) begin
				tx_state <= uart_start;
				uart_tx  <= 1'b0;
			end
			uart_start: begin
				tx_state <= uart_data;
				tx_bit   <= '0;
				uart_tx  <= tx_shift[0];
			end
			uart_data: begin
				tx_bit <= tx_bit + 1'b1;
				if (tx_bit == 3'd7) begin
					tx_state <= uart_stop;
					uart_tx  <= 1'b1;
				end else begin
					uart_tx  <= tx_shift[1];
				end
			end
			uart_stop: tx_state <= uart_idle;
			default: tx_state <= uart_idle;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (tx_state == uart_idle && tx_start)
			tx_shift <= tx_data;
		else if (tx_state == uart_data && tx_cnt == '0)
			tx_shift <= {1'b1, tx_shift[7:1]};
	end

	assign tx_busy = (tx_state != uart_idle);

endmodule

//--- source/fpga_reset.sv
`timescale 1ns/1ps

module fpga_reset #(
	parameter int SHIFT = 3,
	parameter int COUNT = 200
) (
	input  logic clk,
	input  logic force_rst_n,
	output logic rst_n
);

	localparam int W_COUNT = $clog2(COUNT + 1);

	logic [SHIFT-1:0]   sync;
	logic [W_COUNT-1:0] delay;
	logic               rst_n_q;

	// synchronizer clears at once, then fills with ones after release.
	// the counter only runs once the synchronizer output has settled.
	always_ff @(posedge clk or negedge force_rst_n) begin
		if (!force_rst_n) begin
			sync    <= '0;
			delay   <= W_COUNT'(COUNT - 1);
			rst_n_q <= 1'b0;
		end else begin
			sync <= {sync[SHIFT-2:0], 1'b1};
			if (sync[SHIFT-1]) begin
				if (delay != '0) begin
					delay <= delay - 1'b1;
				end else begin
					rst_n_q <= 1'b1;
				end
			end
		end
	end

	// release lands SHIFT + COUNT clocks after force_rst_n rises.
	assign rst_n = rst_n_q;

endmodule

//--- source/riscboy_pkg.sv
package riscboy_pkg;

	// one byte on the serial line, in either direction.
	typedef logic [7:0] uart_byte_t;

	// one bit per gpio pad.
	typedef logic [7:0] gpio_vec_t;

	// opcode field, bits 7:6 of a command byte.
	// the low six bits of the command are don't-care.
	typedef enum logic [1:0] {
		op_read_in   = 2'd0,
		op_write_out = 2'd1,
		op_write_oe  = 2'd2,
		op_read_out  = 2'd3
	} gpio_op_t;

	// command assembly.
	typedef enum logic {
		dec_wait_cmd,
		dec_wait_data
	} decode_state_t;

	// shared by the receiver and the transmitter.
	typedef enum logic [1:0] {
		uart_idle,
		uart_start,
		uart_data,
		uart_stop
	} uart_state_t;

endpackage

//--- source/gpio_pinmap.svh
// pad numbering shared by the board top and the core.
localparam int N_GPIOS    = 8;

// d-pad buttons.
localparam int PIN_DPAD_U = 0;
localparam int PIN_DPAD_D = 1;
localparam int PIN_DPAD_L = 2;
localparam int PIN_DPAD_R = 3;

// user led, driven when padout and padoe are both set.
localparam int PIN_LED    = 4;
